/* verilog/wb_pkg.sv */
package wb_pkg;

    typedef logic [63:0] data_t;     // raw slot result
    typedef logic [31:0] word_t;     // address, eip, general register
    typedef logic [15:0] seg_t;      // segment register value
    typedef logic [2:0]  reg_idx_t;  // low bits of a slot dest
    typedef logic [1:0]  mem_size_t; // 0 byte .. 3 eight bytes

    // bit 3 interrupt, bits 2:0 exception cause
    typedef logic [3:0]  ie_type_t;

    localparam int NUM_SLOTS = 4;

    typedef struct packed {
        data_t data;
        word_t dest;     // reg index in low bits or memory address
        logic  is_reg;
        logic  is_seg;
        logic  is_mem;
        logic  wb;       // slot really writes
    } wb_slot_t;

    typedef struct packed {
        logic                     valid;
        wb_slot_t [NUM_SLOTS-1:0] slot;
        word_t                    eip;
        mem_size_t                op_size;
        logic [3:0]               size_ovr;  // one-hot store size override
        logic                     far_xfer;
        logic                     halt_op;
        logic                     br_valid;
        logic                     br_taken;
        logic                     br_correct;
        word_t                    br_fip;
        logic                     exc;
        logic [2:0]               exc_cause;
        logic                     irq;
    } wb_bundle_t;

    typedef struct packed {
        word_t     addr;
        data_t     data;
        mem_size_t size;
    } store_entry_t;

    typedef struct packed {
        logic  resteer;
        word_t new_eip;
        word_t fip_even;
        word_t fip_odd;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        ie_type_t ie_type;
    } exc_report_t;

endpackage

/* verilog/arch_reg_file.sv */
`timescale 1ns/100ps

module arch_reg_file #(
    parameter int DATA_W = 32
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                  we,
    input  wb_pkg::reg_idx_t [wb_pkg::NUM_SLOTS-1:0]      wr_idx,
    input  logic [wb_pkg::NUM_SLOTS-1:0][DATA_W-1:0]      wr_data,
    input  wb_pkg::reg_idx_t                              rd_addr,
    output logic [DATA_W-1:0]                             rd_data
);

    localparam int NUM_REGS = 8;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // later slots overwrite earlier ones on the same index
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
                if (we[i]) begin
                    regs[wr_idx[i]] <= wr_data[i];
                end
            end
        end
    end

    assign rd_data = regs[rd_addr];   // async read

endmodule

/* verilog/store_queue.sv */
`timescale 1ns/100ps

module store_queue #(
    parameter int DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enq,
    input  wb_pkg::store_entry_t enq_entry,
    input  logic                 mem_ready,
    output logic                 full,
    output logic                 mem_valid,
    output wb_pkg::store_entry_t mem_req
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    wb_pkg::store_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_enq;
    logic             do_deq;

    // wraps at DEPTH so any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign mem_valid = (count != '0);
    assign mem_req   = mem[rd_ptr];       // head of queue

    assign do_enq = enq & ~full;
    assign do_deq = mem_valid & mem_ready;

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // the stage stalls instead of pushing into a full queue
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (reset)
        enq |-> !full
    ) else $error("enq while store queue full");

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= CNT_W'(DEPTH)
    ) else $error("store queue count above depth");

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage (
    input  logic                                          clk,
    input  logic                                          reset,
    input  wb_pkg::wb_bundle_t                            bundle,
    input  logic                                          wbaq_full,
    output logic                                          stall,
    output logic                                          halted,
    output logic [wb_pkg::NUM_SLOTS-1:0]                  gpr_we,
    output logic [wb_pkg::NUM_SLOTS-1:0]                  seg_we,
    output wb_pkg::reg_idx_t [wb_pkg::NUM_SLOTS-1:0]      wr_idx,
    output wb_pkg::data_t [wb_pkg::NUM_SLOTS-1:0]         wr_data,
    output logic                                          enq,
    output wb_pkg::store_entry_t                          enq_entry,
    output wb_pkg::redirect_t                             redirect,
    output wb_pkg::exc_report_t                           exc
);

    logic [wb_pkg::NUM_SLOTS-1:0] mem_hit;   // per slot store request
    logic                         has_store;
    logic                         accept;
    wb_pkg::mem_size_t            ovr_size;
    wb_pkg::mem_size_t            st_size;
    wb_pkg::word_t                fip_line;
    wb_pkg::word_t                fip_next;

    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            mem_hit[i] = bundle.slot[i].is_mem & bundle.slot[i].wb;
        end
    end

    assign has_store = |mem_hit;

    // back-pressure only matters for bundles that carry a store
    assign stall  = bundle.valid & ~halted & has_store & wbaq_full;
    assign accept = bundle.valid & ~halted & ~stall;

    // slot decode
    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            gpr_we[i]  = accept & bundle.slot[i].is_reg & bundle.slot[i].wb;
            seg_we[i]  = accept & bundle.slot[i].is_seg & bundle.slot[i].wb;
            wr_idx[i]  = bundle.slot[i].dest[2:0];
            wr_data[i] = bundle.slot[i].data;
        end
        // far transfer: first slot holds cs selector above the target eip
        if (bundle.far_xfer) begin
            wr_data[0] = {48'h0, bundle.slot[0].data[47:32]};
        end
    end

    // size override is one-hot, lowest set bit taken
    always_comb begin
        ovr_size = '0;
        for (int i = 3; i >= 0; i--) begin
            if (bundle.size_ovr[i]) begin
                ovr_size = wb_pkg::mem_size_t'(i);
            end
        end
        if (|bundle.size_ovr) begin
            st_size = ovr_size;
        end else if (bundle.far_xfer) begin
            st_size = 2'd3;          // selector plus eip
        end else begin
            st_size = bundle.op_size;
        end
    end

    // lowest numbered memory slot wins
    always_comb begin
        enq_entry.addr = '0;
        enq_entry.data = '0;
        for (int i = wb_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                enq_entry.addr = bundle.slot[i].dest;
                enq_entry.data = bundle.slot[i].data;
            end
        end
        enq_entry.size = st_size;
    end

    assign enq = accept & has_store;

    // even/odd fetch lines around the branch target
    assign fip_line = {bundle.br_fip[31:4], 4'h0};
    assign fip_next = fip_line + 32'd16;

    always_comb begin
        redirect = '0;
        if (accept) begin
            redirect.resteer  = (bundle.br_valid & ~bundle.br_correct) | bundle.far_xfer;
            redirect.fip_even = bundle.br_fip[4] ? fip_next : fip_line;
            redirect.fip_odd  = bundle.br_fip[4] ? fip_line : fip_next;
            if (bundle.far_xfer) begin
                redirect.new_eip = bundle.slot[0].data[31:0];
            end else if (bundle.br_taken) begin
                redirect.new_eip = bundle.br_fip;
            end else begin
                redirect.new_eip = bundle.eip;
            end
        end
    end

    // reported on valid alone, stall does not hide it
    assign exc.valid   = bundle.valid & (bundle.exc | bundle.irq);
    assign exc.ie_type = bundle.valid ? {bundle.irq, bundle.exc_cause} : '0;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (accept & bundle.halt_op) begin
            halted <= 1'b1;
        end
    end

    // decode upstream sends a single store per bundle
    a_one_mem_slot: assert property (
        @(posedge clk) disable iff (reset)
        bundle.valid |-> $countones(mem_hit) <= 1
    ) else $error("more than one memory slot in a valid bundle");

    // size override arrives one-hot, the size rule takes its lowest bit
    a_size_ovr_onehot: assert property (
        @(posedge clk) disable iff (reset)
        bundle.valid |-> $onehot0(bundle.size_ovr)
    ) else $error("size override not one-hot in a valid bundle");

endmodule

/* verilog/writeback_top.sv */
`timescale 1ns/100ps

module writeback_top #(
    parameter int DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_pkg::wb_bundle_t   bundle,
    input  wb_pkg::reg_idx_t     gpr_rd_addr,
    input  wb_pkg::reg_idx_t     seg_rd_addr,
    input  logic                 mem_ready,
    output logic                 stall,
    output logic                 halted,
    output wb_pkg::redirect_t    redirect,
    output wb_pkg::exc_report_t  exc,
    output wb_pkg::word_t        gpr_rd_data,
    output wb_pkg::seg_t         seg_rd_data,
    output logic                 mem_valid,
    output wb_pkg::store_entry_t mem_req
);

    logic [wb_pkg::NUM_SLOTS-1:0]             gpr_we;
    logic [wb_pkg::NUM_SLOTS-1:0]             seg_we;
    wb_pkg::reg_idx_t [wb_pkg::NUM_SLOTS-1:0] wr_idx;
    wb_pkg::data_t [wb_pkg::NUM_SLOTS-1:0]    wr_data;
    wb_pkg::word_t [wb_pkg::NUM_SLOTS-1:0]    gpr_wr_data;
    wb_pkg::seg_t [wb_pkg::NUM_SLOTS-1:0]     seg_wr_data;
    logic                                     enq;
    wb_pkg::store_entry_t                     enq_entry;
    logic                                     wbaq_full;

    writeback_stage u_stage (
        .clk       (clk),
        .reset     (reset),
        .bundle    (bundle),
        .wbaq_full (wbaq_full),
        .stall     (stall),
        .halted    (halted),
        .gpr_we    (gpr_we),
        .seg_we    (seg_we),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .enq       (enq),
        .enq_entry (enq_entry),
        .redirect  (redirect),
        .exc       (exc)
    );

    // each file keeps only its own width of the slot result
    for (genvar i = 0; i < wb_pkg::NUM_SLOTS; i++) begin : g_trunc
        assign gpr_wr_data[i] = wr_data[i][31:0];
        assign seg_wr_data[i] = wr_data[i][15:0];
    end

    arch_reg_file #(
        .DATA_W (32)
    ) u_gpr (
        .clk     (clk),
        .reset   (reset),
        .we      (gpr_we),
        .wr_idx  (wr_idx),
        .wr_data (gpr_wr_data),
        .rd_addr (gpr_rd_addr),
        .rd_data (gpr_rd_data)
    );

    arch_reg_file #(
        .DATA_W (16)
    ) u_seg (
        .clk     (clk),
        .reset   (reset),
        .we      (seg_we),
        .wr_idx  (wr_idx),
        .wr_data (seg_wr_data),
        .rd_addr (seg_rd_addr),
        .rd_data (seg_rd_data)
    );

    store_queue #(
        .DEPTH (DEPTH)
    ) u_wbaq (
        .clk       (clk),
        .reset     (reset),
        .enq       (enq),
        .enq_entry (enq_entry),
        .mem_ready (mem_ready),
        .full      (wbaq_full),
        .mem_valid (mem_valid),
        .mem_req   (mem_req)
    );

endmodule

/* testbench/tb_writeback_top.sv */
`timescale 1ns/100ps

module tb_writeback_top;

    localparam int DEPTH   = 4;
    localparam int SEED    = 51508;
    localparam int REG_N   = 100;
    localparam int STORE_N = 80;
    localparam int REDIR_N = 80;
    localparam int EXC_N   = 60;
    localparam int HALT_N  = 12;

    // stores wait about two cycles each behind a random mem_ready
    localparam int PLAN_CYCLES = REG_N + 3 * STORE_N + 4 * DEPTH + REDIR_N + EXC_N
                                 + HALT_N + 80;
    localparam int TIMEOUT_CYCLES = 2 * PLAN_CYCLES;

    logic                 clk;
    logic                 reset;
    wb_pkg::wb_bundle_t   bundle;
    wb_pkg::reg_idx_t     gpr_rd_addr;
    wb_pkg::reg_idx_t     seg_rd_addr;
    logic                 mem_ready;
    logic                 stall;
    logic                 halted;
    wb_pkg::redirect_t    redirect;
    wb_pkg::exc_report_t  exc;
    wb_pkg::word_t        gpr_rd_data;
    wb_pkg::seg_t         seg_rd_data;
    logic                 mem_valid;
    wb_pkg::store_entry_t mem_req;

    // reference model state
    wb_pkg::word_t        gpr_m [8];
    wb_pkg::seg_t         seg_m [8];
    wb_pkg::store_entry_t exp_q [$];
    wb_pkg::store_entry_t q_head;
    int                   q_count;
    logic                 halted_m;

    // expected outputs for the current bundle
    logic                 has_store_x;
    logic                 stall_x;
    logic                 accept_x;
    wb_pkg::word_t        fip_line_x;
    wb_pkg::redirect_t    redirect_x;
    wb_pkg::exc_report_t  exc_x;
    wb_pkg::word_t        gpr_rd_x;
    wb_pkg::seg_t         seg_rd_x;

    int ready_mode;     // 0 low, 1 high, 2 random
    int err_count;
    int test_count;
    int test_err_base;
    int cycle_count;

    writeback_top #(
        .DEPTH (DEPTH)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .bundle      (bundle),
        .gpr_rd_addr (gpr_rd_addr),
        .seg_rd_addr (seg_rd_addr),
        .mem_ready   (mem_ready),
        .stall       (stall),
        .halted      (halted),
        .redirect    (redirect),
        .exc         (exc),
        .gpr_rd_data (gpr_rd_data),
        .seg_rd_data (seg_rd_data),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req)
    );

    always #10 clk = ~clk;

    function automatic logic bundle_has_store(input wb_pkg::wb_bundle_t b);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            hit = hit | (b.slot[i].is_mem & b.slot[i].wb);
        end
        return hit;
    endfunction

    // far transfer sends the cs selector through the first write port
    function automatic wb_pkg::data_t port_data(input wb_pkg::wb_bundle_t b, input int i);
        if (i == 0 && b.far_xfer) begin
            return {48'h0, b.slot[0].data[47:32]};
        end
        return b.slot[i].data;
    endfunction

    function automatic wb_pkg::mem_size_t store_size(input wb_pkg::wb_bundle_t b);
        casez (b.size_ovr)
            4'b???1: return 2'd0;
            4'b??10: return 2'd1;
            4'b?100: return 2'd2;
            4'b1000: return 2'd3;
            default: return b.far_xfer ? 2'd3 : b.op_size;
        endcase
    endfunction

    function automatic wb_pkg::store_entry_t store_of(input wb_pkg::wb_bundle_t b);
        wb_pkg::store_entry_t e;
        logic                 found;
        e = '0;
        found = 1'b0;
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            if (!found && b.slot[i].is_mem && b.slot[i].wb) begin
                e.addr = b.slot[i].dest;
                e.data = b.slot[i].data;
                found  = 1'b1;
            end
        end
        e.size = store_size(b);
        return e;
    endfunction

    // random valid bundle, at most one store slot
    function automatic wb_pkg::wb_bundle_t make_bundle(input bit with_store, input bit collide);
        wb_pkg::wb_bundle_t b;
        int                 m;
        logic [2:0]         base;
        b = '0;
        b.valid = 1'b1;
        base = 3'($urandom_range(0, 7));
        m = with_store ? int'($urandom_range(0, 3)) : -1;
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            b.slot[i].data   = {$urandom, $urandom};
            b.slot[i].dest   = $urandom;
            if (collide && $urandom_range(0, 1) != 0) begin
                b.slot[i].dest[2:0] = base;   // same index as a sibling slot
            end
            b.slot[i].is_reg = 1'($urandom);
            b.slot[i].is_seg = 1'($urandom);
            b.slot[i].is_mem = (i == m);
            b.slot[i].wb     = (i == m) ? 1'b1 : ($urandom_range(0, 3) != 0);
        end
        b.eip        = $urandom;
        b.op_size    = 2'($urandom);
        b.size_ovr   = ($urandom_range(0, 1) != 0) ? 4'(1 << $urandom_range(0, 3)) : 4'h0;
        b.far_xfer   = ($urandom_range(0, 3) == 0);
        b.br_valid   = 1'($urandom);
        b.br_taken   = 1'($urandom);
        b.br_correct = 1'($urandom);
        b.br_fip     = $urandom;
        b.exc        = ($urandom_range(0, 3) == 0);
        b.exc_cause  = 3'($urandom);
        b.irq        = ($urandom_range(0, 3) == 0);
        return b;
    endfunction

    always_comb begin
        has_store_x = bundle_has_store(bundle);
        stall_x     = bundle.valid & ~halted_m & has_store_x & (q_count == DEPTH);
        accept_x    = bundle.valid & ~halted_m & ~stall_x;
        fip_line_x  = bundle.br_fip & 32'hffff_fff0;
        redirect_x  = '0;
        if (accept_x) begin
            redirect_x.resteer = (bundle.br_valid & ~bundle.br_correct) | bundle.far_xfer;
            if (bundle.br_fip[4]) begin   // odd line first
                redirect_x.fip_even = fip_line_x + 32'd16;
                redirect_x.fip_odd  = fip_line_x;
            end else begin
                redirect_x.fip_even = fip_line_x;
                redirect_x.fip_odd  = fip_line_x + 32'd16;
            end
            if (bundle.far_xfer) begin
                redirect_x.new_eip = bundle.slot[0].data[31:0];
            end else if (bundle.br_taken) begin
                redirect_x.new_eip = bundle.br_fip;
            end else begin
                redirect_x.new_eip = bundle.eip;
            end
        end
        exc_x.valid   = bundle.valid & (bundle.exc | bundle.irq);
        exc_x.ie_type = bundle.valid ? {bundle.irq, bundle.exc_cause} : 4'h0;
        gpr_rd_x = gpr_m[gpr_rd_addr];
        seg_rd_x = seg_m[seg_rd_addr];
    end

    // model advances on the same edge as the DUT
    always @(posedge clk) begin
        logic          acc;
        wb_pkg::data_t d;
        acc = accept_x;
        if (reset) begin
            for (int r = 0; r < 8; r++) begin
                gpr_m[r] = '0;
                seg_m[r] = '0;
            end
            exp_q.delete();
            halted_m = 1'b0;
        end else begin
            if (q_count != 0 && mem_ready) begin
                void'(exp_q.pop_front());
            end
            if (acc) begin
                for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin   // later slot wins
                    d = port_data(bundle, i);
                    if (bundle.slot[i].is_reg && bundle.slot[i].wb) begin
                        gpr_m[bundle.slot[i].dest[2:0]] = d[31:0];
                    end
                    if (bundle.slot[i].is_seg && bundle.slot[i].wb) begin
                        seg_m[bundle.slot[i].dest[2:0]] = d[15:0];
                    end
                end
                if (has_store_x) begin
                    exp_q.push_back(store_of(bundle));
                end
                if (bundle.halt_op) begin
                    halted_m = 1'b1;
                end
            end
        end
        q_count = exp_q.size();
        q_head  = (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        $display("mismatch at %0t ns: %s expected 'h%0h, got 'h%0h", $time, name, exp_v, act_v);
        err_count++;
    endtask

    a_stall: assert property (@(posedge clk) disable iff (reset) stall == stall_x)
        else report_mismatch("stall", 128'($sampled(stall_x)), 128'($sampled(stall)));
    a_halted: assert property (@(posedge clk) disable iff (reset) halted == halted_m)
        else report_mismatch("halted", 128'($sampled(halted_m)), 128'($sampled(halted)));
    a_redirect: assert property (@(posedge clk) disable iff (reset) redirect == redirect_x)
        else report_mismatch("redirect", 128'($sampled(redirect_x)), 128'($sampled(redirect)));
    a_exc: assert property (@(posedge clk) disable iff (reset) exc == exc_x)
        else report_mismatch("exc", 128'($sampled(exc_x)), 128'($sampled(exc)));
    a_gpr: assert property (@(posedge clk) disable iff (reset) gpr_rd_data == gpr_rd_x)
        else report_mismatch("gpr_rd_data", 128'($sampled(gpr_rd_x)),
                             128'($sampled(gpr_rd_data)));
    a_seg: assert property (@(posedge clk) disable iff (reset) seg_rd_data == seg_rd_x)
        else report_mismatch("seg_rd_data", 128'($sampled(seg_rd_x)),
                             128'($sampled(seg_rd_data)));
    a_mem_valid: assert property (@(posedge clk) disable iff (reset)
        mem_valid == (q_count != 0))
        else report_mismatch("mem_valid", 128'($sampled(q_count != 0)),
                             128'($sampled(mem_valid)));
    a_mem_req: assert property (@(posedge clk) disable iff (reset)
        (mem_valid && mem_ready) |-> mem_req == q_head)
        else report_mismatch("mem_req", 128'($sampled(q_head)), 128'($sampled(mem_req)));

    // read ports walk all indices, mem_ready follows the mode
    always @(negedge clk) begin
        gpr_rd_addr = gpr_rd_addr + 3'd1;
        seg_rd_addr = seg_rd_addr - 3'd1;
        case (ready_mode)
            0:       mem_ready = 1'b0;
            1:       mem_ready = 1'b1;
            default: mem_ready = 1'($urandom);
        endcase
    end

    // holds the bundle while the DUT stalls
    task automatic send_bundle(input wb_pkg::wb_bundle_t b);
        @(negedge clk);
        bundle = b;
        #1;
        while (stall) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic drive_cycle(input wb_pkg::wb_bundle_t b);
        @(negedge clk);
        bundle = b;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        bundle = '0;
    endtask

    task automatic end_test(input string name);
        drive_idle();
        ready_mode = 1;
        while (q_count != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        test_count++;
        $display("test %0d %s finished with %0d errors", test_count, name,
                 err_count - test_err_base);
        test_err_base = err_count;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        wb_pkg::wb_bundle_t b;
        wb_pkg::wb_bundle_t b2;
        clk           = 1'b0;
        reset         = 1'b1;
        bundle        = '0;
        gpr_rd_addr   = '0;
        seg_rd_addr   = '0;
        mem_ready     = 1'b0;
        ready_mode    = 1;
        err_count     = 0;
        test_count    = 0;
        test_err_base = 0;
        void'($urandom(SEED));
        repeat (2) @(negedge clk);
        reset = 1'b0;

        for (int k = 0; k < REG_N; k++) begin
            send_bundle(make_bundle(1'b0, 1'b1));
        end
        end_test("register_writes");

        ready_mode = 2;
        for (int k = 0; k < STORE_N; k++) begin
            send_bundle(make_bundle(1'b1, 1'b0));
        end
        end_test("stores");

        ready_mode = 0;
        for (int k = 0; k < DEPTH; k++) begin
            send_bundle(make_bundle(1'b1, 1'b0));
        end
        b = make_bundle(1'b1, 1'b1);
        repeat (3) drive_cycle(b);     // queue full, must stall
        b2 = make_bundle(1'b0, 1'b1);
        send_bundle(b2);               // no store, goes through
        ready_mode = 1;
        send_bundle(b);
        end_test("back_pressure");

        ready_mode = 2;
        for (int k = 0; k < REDIR_N; k++) begin
            b = make_bundle(1'($urandom), 1'b0);
            b.valid = ($urandom_range(0, 3) != 0);
            drive_cycle(b);
        end
        end_test("redirect");

        for (int k = 0; k < EXC_N; k++) begin
            b = make_bundle(1'b0, 1'b0);
            b.valid = 1'($urandom);
            b.exc   = 1'($urandom);
            b.irq   = 1'($urandom);
            drive_cycle(b);
        end
        end_test("exceptions");

        b = make_bundle(1'b0, 1'b0);
        b.halt_op = 1'b1;
        send_bundle(b);
        ready_mode = 2;
        for (int k = 0; k < HALT_N; k++) begin
            send_bundle(make_bundle(1'b1, 1'b1));
        end
        drive_idle();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < 4; k++) begin
            send_bundle(make_bundle(1'b0, 1'b0));
        end
        end_test("halt");

        $display("summary: %0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/wb_pkg.sv
verilog/arch_reg_file.sv
verilog/store_queue.sv
verilog/writeback_stage.sv
verilog/writeback_top.sv
testbench/tb_writeback_top.sv

/* Makefile */
TOP = tb_writeback_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
